//--- hw/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    localparam logic [6:0] op_reg    = 7'h33;
    localparam logic [6:0] op_imm    = 7'h13;
    localparam logic [6:0] op_branch = 7'h63;
    localparam logic [6:0] op_jal    = 7'h6f;
    localparam logic [6:0] op_jalr   = 7'h67;
    localparam logic [6:0] op_lui    = 7'h37;
    localparam logic [6:0] op_auipc  = 7'h17;
    localparam logic [6:0] op_store  = 7'h23;
    localparam logic [6:0] op_system = 7'h73;
    localparam logic [31:0] ebreak_inst = 32'h0010_0073;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu
    } br_op_e;

    typedef enum logic [2:0] {
        class_r, class_i, class_b, class_u, class_j, class_n, class_bad
    } inst_class_e;

    typedef enum logic [1:0] {
        halt_none, halt_ebreak, halt_illegal, halt_bus_error
    } halt_cause_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
    } rv_fetch_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] imm;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        alu_op_e         alu_op;
        br_op_e          br_op;
        logic            src1_is_pc;
        logic            src2_is_imm;
        logic            is_jump;
        logic            is_jalr;
        logic            gpr_we;
        inst_class_e     inst_class;
    } rv_decode_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] next_pc;
        logic [xlen-1:0] wdata;
        logic [4:0]      rd;
        logic            gpr_we;
        inst_class_e     inst_class;
    } rv_retire_t;

    typedef struct packed {
        logic [31:0] cycles;
        logic [31:0] retired;
        logic [15:0] r_cnt;
        logic [15:0] i_cnt;
        logic [15:0] b_cnt;
        logic [15:0] u_cnt;
        logic [15:0] j_cnt;
    } rv_perf_t;

endpackage

//--- hw/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetch_start,
    input  logic [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] paddr,
    output logic                    psel,
    output logic                    penable,
    input  logic [31:0]             prdata,
    input  logic                    pready,
    input  logic                    pslverr,
    output rv_pkg::rv_fetch_t       fetch,
    output logic                    fetch_valid,
    input  logic                    fetch_ready,
    output logic                    fetch_err
);
    typedef enum logic [1:0] {st_idle, st_setup, st_access, st_hold} fetch_state_e;

    fetch_state_e state;

    assign paddr = fetch.pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= st_idle;
            psel        <= 1'b0;
            penable     <= 1'b0;
            fetch_valid <= 1'b0;
            fetch_err   <= 1'b0;
        end else begin
            fetch_err <= 1'b0;
            case (state)
                st_idle: begin
                    if (fetch_start) begin
                        psel  <= 1'b1;  // Setup phase.
                        state <= st_setup;
                    end
                end
                st_setup: begin
                    penable <= 1'b1;
                    state   <= st_access;
                end
                st_access: begin
                    if (pready) begin
                        psel    <= 1'b0;
                        penable <= 1'b0;
                        if (pslverr) begin
                            fetch_err <= 1'b1;  // No word handed on.
                            state     <= st_idle;
                        end else begin
                            fetch_valid <= 1'b1;
                            state       <= st_hold;
                        end
                    end
                end
                st_hold: begin
                    if (fetch_ready) begin
                        fetch_valid <= 1'b0;
                        state       <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && fetch_start) begin
            fetch.pc <= pc;
        end
        if (state == st_access && pready) begin
            fetch.inst <= prdata;
        end
    end

endmodule

//--- hw/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic               clk,
    input  logic               rst,
    input  rv_pkg::rv_fetch_t  fetch,
    input  logic               fetch_valid,
    output logic               fetch_ready,
    output rv_pkg::rv_decode_t dec,
    output logic               dec_valid,
    input  logic               dec_ready
);
    import rv_pkg::*;

    typedef enum logic {st_idle, st_busy} dec_state_e;

    dec_state_e  state;
    rv_fetch_t   fetch_q;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        r_ok;
    logic        i_ok;

    assign fetch_ready = (state == st_idle);
    assign dec_valid   = (state == st_busy);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: state <= (fetch_valid && fetch_ready) ? st_busy : st_idle;
                st_busy: state <= dec_ready ? st_idle : st_busy;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && fetch_ready) begin
            fetch_q <= fetch;
        end
    end

    assign opcode = fetch_q.inst[6:0];
    assign funct3 = fetch_q.inst[14:12];
    assign funct7 = fetch_q.inst[31:25];

    assign imm_i = {{20{fetch_q.inst[31]}}, fetch_q.inst[31:20]};
    assign imm_s = {{20{fetch_q.inst[31]}}, fetch_q.inst[31:25], fetch_q.inst[11:7]};
    assign imm_b = {{20{fetch_q.inst[31]}}, fetch_q.inst[7], fetch_q.inst[30:25],
                    fetch_q.inst[11:8], 1'b0};
    assign imm_u = {fetch_q.inst[31:12], 12'b0};
    assign imm_j = {{12{fetch_q.inst[31]}}, fetch_q.inst[19:12], fetch_q.inst[20],
                    fetch_q.inst[30:21], 1'b0};

    // Only sub and sra take funct7 0x20.
    assign r_ok = (funct7 == 7'h00) ||
                  (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign i_ok = (funct3 == 3'b001) ? (funct7 == 7'h00) :
                  (funct3 == 3'b101) ? (funct7 == 7'h00 || funct7 == 7'h20) :
                  (funct3 != 3'b010);  // slti is not supported.

    always_comb begin
        dec            = '0;
        dec.pc         = fetch_q.pc;
        dec.rs1        = fetch_q.inst[19:15];
        dec.rs2        = fetch_q.inst[24:20];
        dec.rd         = fetch_q.inst[11:7];
        dec.alu_op     = alu_add;
        dec.br_op      = br_none;
        dec.inst_class = class_bad;
        case (opcode)
            op_lui, op_auipc: dec.imm = imm_u;
            op_jal:           dec.imm = imm_j;
            op_branch:        dec.imm = imm_b;
            op_store:         dec.imm = imm_s;
            default:          dec.imm = imm_i;
        endcase
        case (funct3)
            3'b001:  dec.alu_op = alu_sll;
            3'b010:  dec.alu_op = alu_slt;
            3'b011:  dec.alu_op = alu_sltu;
            3'b100:  dec.alu_op = alu_xor;
            3'b101:  dec.alu_op = funct7[5] ? alu_sra : alu_srl;
            3'b110:  dec.alu_op = alu_or;
            3'b111:  dec.alu_op = alu_and;
            default: dec.alu_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
        endcase
        case (opcode)
            op_reg: begin
                if (r_ok) begin
                    dec.gpr_we     = 1'b1;
                    dec.inst_class = class_r;
                end
            end
            op_imm: begin
                dec.src2_is_imm = 1'b1;
                if (i_ok) begin
                    dec.gpr_we     = 1'b1;
                    dec.inst_class = class_i;
                end
            end
            op_branch: begin
                dec.alu_op      = alu_add;  // Target is pc plus imm.
                dec.src1_is_pc  = 1'b1;
                dec.src2_is_imm = 1'b1;
                case (funct3)
                    3'b000:  dec.br_op = br_eq;
                    3'b001:  dec.br_op = br_ne;
                    3'b100:  dec.br_op = br_lt;
                    3'b101:  dec.br_op = br_ge;
                    3'b110:  dec.br_op = br_ltu;
                    3'b111:  dec.br_op = br_geu;
                    default: dec.br_op = br_none;
                endcase
                if (dec.br_op != br_none) begin
                    dec.inst_class = class_b;
                end
            end
            op_jal: begin
                dec.alu_op      = alu_add;
                dec.src1_is_pc  = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.is_jump     = 1'b1;
                dec.gpr_we      = 1'b1;
                dec.inst_class  = class_j;
            end
            op_jalr: begin
                dec.alu_op      = alu_add;
                dec.src2_is_imm = 1'b1;
                if (funct3 == 3'b000) begin
                    dec.is_jump    = 1'b1;
                    dec.is_jalr    = 1'b1;
                    dec.gpr_we     = 1'b1;
                    dec.inst_class = class_i;
                end
            end
            op_lui, op_auipc: begin
                dec.alu_op      = (opcode == op_lui) ? alu_pass_b : alu_add;
                dec.src1_is_pc  = (opcode == op_auipc);
                dec.src2_is_imm = 1'b1;
                dec.gpr_we      = 1'b1;
                dec.inst_class  = class_u;
            end
            op_system: begin
                if (fetch_q.inst == ebreak_inst) begin
                    dec.inst_class = class_n;
                end
            end
            default: dec.inst_class = class_bad;
        endcase
    end

endmodule

//--- hw/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    output logic [rv_pkg::xlen-1:0] rdata1,
    output logic [rv_pkg::xlen-1:0] rdata2,
    input  rv_pkg::rv_retire_t      wb,
    input  logic                    wb_valid
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_valid && wb.gpr_we && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.wdata;  // x0 is never written.
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- hw/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_pkg::rv_decode_t      dec,
    input  logic                    dec_valid,
    output logic                    dec_ready,
    input  logic [rv_pkg::xlen-1:0] rdata1,
    input  logic [rv_pkg::xlen-1:0] rdata2,
    output rv_pkg::rv_retire_t      retire,
    output logic                    retire_valid
);
    import rv_pkg::*;

    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] target;
    logic            taken;

    assign src1 = dec.src1_is_pc ? dec.pc : rdata1;
    assign src2 = dec.src2_is_imm ? dec.imm : rdata2;

    always_comb begin
        case (dec.alu_op)
            alu_sub:    alu_res = src1 - src2;
            alu_sll:    alu_res = src1 << src2[4:0];
            alu_slt:    alu_res = {31'b0, $signed(src1) < $signed(src2)};
            alu_sltu:   alu_res = {31'b0, src1 < src2};
            alu_xor:    alu_res = src1 ^ src2;
            alu_srl:    alu_res = src1 >> src2[4:0];
            alu_sra:    alu_res = $unsigned($signed(src1) >>> src2[4:0]);
            alu_or:     alu_res = src1 | src2;
            alu_and:    alu_res = src1 & src2;
            alu_pass_b: alu_res = src2;
            default:    alu_res = src1 + src2;
        endcase
    end

    // Compare always uses the register operands.
    always_comb begin
        case (dec.br_op)
            br_eq:   taken = (rdata1 == rdata2);
            br_ne:   taken = (rdata1 != rdata2);
            br_lt:   taken = ($signed(rdata1) < $signed(rdata2));
            br_ge:   taken = ($signed(rdata1) >= $signed(rdata2));
            br_ltu:  taken = (rdata1 < rdata2);
            br_geu:  taken = (rdata1 >= rdata2);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4  = dec.pc + 32'd4;
    assign target    = {alu_res[xlen-1:1], alu_res[0] & ~dec.is_jalr};
    assign dec_ready = ~retire_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= dec_valid && dec_ready;  // One-cycle pulse.
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            retire.pc         <= dec.pc;
            retire.next_pc    <= (taken || dec.is_jump) ? target : pc_plus4;
            retire.wdata      <= dec.is_jump ? pc_plus4 : alu_res;  // Link value.
            retire.rd         <= dec.rd;
            retire.gpr_we     <= dec.gpr_we;
            retire.inst_class <= dec.inst_class;
        end
    end

endmodule

//--- hw/rv_sequencer.sv
`timescale 1ns/1ps

module rv_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    output logic                    fetch_start,
    output logic [rv_pkg::xlen-1:0] pc,
    input  logic                    fetch_err,
    input  rv_pkg::rv_retire_t      retire,
    input  logic                    retire_valid,
    output logic                    halted,
    output rv_pkg::halt_cause_e     halt_cause
);
    import rv_pkg::*;

    typedef enum logic [1:0] {st_boot, st_fetch, st_wait_retire, st_halt} seq_state_e;

    seq_state_e state;

    assign fetch_start = (state == st_fetch);
    assign halted      = (state == st_halt);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_boot;
            pc         <= reset_pc;
            halt_cause <= halt_none;
        end else begin
            case (state)
                st_boot:  state <= st_fetch;
                st_fetch: state <= st_wait_retire;
                st_wait_retire: begin
                    if (fetch_err) begin
                        state      <= st_halt;
                        halt_cause <= halt_bus_error;
                    end else if (retire_valid) begin
                        pc <= retire.next_pc;
                        if (retire.inst_class == class_n) begin
                            state      <= st_halt;
                            halt_cause <= halt_ebreak;
                        end else if (retire.inst_class == class_bad) begin
                            state      <= st_halt;
                            halt_cause <= halt_illegal;
                        end else begin
                            state <= st_fetch;
                        end
                    end
                end
                st_halt:  state <= st_halt;  // Held until reset.
                default:  state <= st_boot;
            endcase
        end
    end

endmodule

//--- hw/rv_perf_counter.sv
`timescale 1ns/1ps

module rv_perf_counter (
    input  logic               clk,
    input  logic               rst,
    input  rv_pkg::rv_retire_t retire,
    input  logic               retire_valid,
    input  logic               halted,
    output rv_pkg::rv_perf_t   perf
);
    import rv_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            perf <= '0;
        end else begin
            if (!halted) begin
                perf.cycles <= perf.cycles + 32'd1;
            end
            if (retire_valid) begin
                perf.retired <= perf.retired + 32'd1;
                case (retire.inst_class)
                    class_r: perf.r_cnt <= perf.r_cnt + 16'd1;
                    class_i: perf.i_cnt <= perf.i_cnt + 16'd1;
                    class_b: perf.b_cnt <= perf.b_cnt + 16'd1;
                    class_u: perf.u_cnt <= perf.u_cnt + 16'd1;
                    class_j: perf.j_cnt <= perf.j_cnt + 16'd1;
                    default: ;  // ebreak and illegal have no counter.
                endcase
            end
        end
    end

endmodule

//--- hw/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    rst,
    output logic [rv_pkg::xlen-1:0] paddr,
    output logic                    psel,
    output logic                    penable,
    input  logic [31:0]             prdata,
    input  logic                    pready,
    input  logic                    pslverr,
    output rv_pkg::rv_retire_t      retire,
    output logic                    retire_valid,
    output logic                    halted,
    output rv_pkg::halt_cause_e     halt_cause,
    output rv_pkg::rv_perf_t        perf
);
    import rv_pkg::*;

    logic            fetch_start;
    logic [xlen-1:0] pc;
    rv_fetch_t       fetch;
    logic            fetch_valid;
    logic            fetch_ready;
    logic            fetch_err;
    rv_decode_t      dec;
    logic            dec_valid;
    logic            dec_ready;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;

    rv_fetch u_fetch (
        .clk, .rst, .fetch_start, .pc, .paddr, .psel, .penable,
        .prdata, .pready, .pslverr, .fetch, .fetch_valid, .fetch_ready, .fetch_err
    );

    rv_decode u_decode (
        .clk, .rst, .fetch, .fetch_valid, .fetch_ready, .dec, .dec_valid, .dec_ready
    );

    rv_regfile u_regfile (
        .clk, .rst, .rs1(dec.rs1), .rs2(dec.rs2), .rdata1, .rdata2,
        .wb(retire), .wb_valid(retire_valid)
    );

    rv_execute u_execute (
        .clk, .rst, .dec, .dec_valid, .dec_ready, .rdata1, .rdata2, .retire, .retire_valid
    );

    rv_sequencer u_sequencer (
        .clk, .rst, .fetch_start, .pc, .fetch_err, .retire, .retire_valid,
        .halted, .halt_cause
    );

    rv_perf_counter u_perf (
        .clk, .rst, .retire, .retire_valid, .halted, .perf
    );

endmodule

//--- tb/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    logic             clk;
    logic             rst;
    logic [xlen-1:0]  paddr;
    logic             psel;
    logic             penable;
    logic [31:0]      prdata;
    logic             pready;
    logic             pslverr;
    rv_retire_t       retire;
    logic             retire_valid;
    logic             halted;
    halt_cause_e      halt_cause;
    rv_perf_t         perf;

    logic [31:0] t_inst  [64];  // Program and expected retire, one row per word.
    logic [4:0]  t_rd    [64];
    logic [31:0] t_wdata [64];
    logic [31:0] t_next  [64];
    inst_class_e t_class [64];
    int          n_rows;

    logic [31:0] mem [256];
    logic [31:0] err_addr;
    integer      seed;
    int          waits_left;
    int          last_waits;

    rv_core u_dut (
        .clk, .rst, .paddr, .psel, .penable, .prdata, .pready, .pslverr,
        .retire, .retire_valid, .halted, .halt_cause, .perf
    );

    always #4 clk = ~clk;

    // APB memory with random wait states.
    always @(posedge clk) begin
        #1;
        if (psel && !penable) begin
            waits_left = $random(seed) & 3;
            last_waits = waits_left;
            pready     = 1'b0;
        end else if (psel && penable) begin
            if (waits_left == 0) begin
                pready  = 1'b1;
                prdata  = mem[paddr[9:2]];
                pslverr = (paddr == err_addr);
            end else begin
                waits_left = waits_left - 1;
                pready     = 1'b0;
            end
        end else begin
            pready  = 1'b0;
            pslverr = 1'b0;
        end
    end

    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(int imm, int rd, logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic logic writes_gpr(inst_class_e cls);
        return cls inside {class_r, class_i, class_u, class_j};
    endfunction

    task automatic add_row(input logic [31:0] inst, input int rd, input logic [31:0] wdata,
                           input logic [31:0] next_pc, input inst_class_e cls);
        t_inst[n_rows]  = inst;
        t_rd[n_rows]    = rd[4:0];
        t_wdata[n_rows] = wdata;
        t_next[n_rows]  = next_pc;
        t_class[n_rows] = cls;
        n_rows          = n_rows + 1;
    endtask

    task automatic add_branch(input logic [31:0] inst, input logic [31:0] next_pc);
        add_row(inst, 0, 32'h0, next_pc, class_b);
    endtask

    task automatic add_skip();
        add_row(enc_i(99, 0, 0, 1, op_imm), 0, 32'h0, 32'h0, class_bad);  // Must never retire.
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_retire(input string name, input rv_retire_t exp, input rv_retire_t act);
        rv_retire_t seen;
        seen = act;
        if (!exp.gpr_we) begin
            seen.wdata = exp.wdata;  // Nothing is written.
            seen.rd    = exp.rd;
        end
        if (seen !== exp) begin
            report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_cause(input string name, input halt_cause_e exp, input halt_cause_e act);
        if (exp !== act) begin
            report_failure($sformatf("mismatch %s: expected %s, actual %s",
                                     name, exp.name(), act.name()));
        end
    endtask

    task automatic check_perf(input string name, input rv_perf_t exp, input rv_perf_t act);
        if (exp !== act) begin
            report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            report_failure($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic build_main();
        n_rows   = 0;
        err_addr = 32'hffff_ffff;
        add_row(enc_i(5, 0, 0, 1, op_imm),          1, 32'h0000_0005, 32'h04, class_i);
        add_row(enc_i(-3, 0, 0, 2, op_imm),         2, 32'hffff_fffd, 32'h08, class_i);
        add_row(enc_r(0, 2, 1, 0, 3),               3, 32'h0000_0002, 32'h0c, class_r);
        add_row(enc_r(32, 2, 1, 0, 4),              4, 32'h0000_0008, 32'h10, class_r);  // sub
        add_row(enc_r(0, 2, 1, 7, 5),               5, 32'h0000_0005, 32'h14, class_r);
        add_row(enc_r(0, 2, 1, 6, 6),               6, 32'hffff_fffd, 32'h18, class_r);
        add_row(enc_r(0, 2, 1, 4, 7),               7, 32'hffff_fff8, 32'h1c, class_r);
        add_row(enc_r(0, 1, 1, 1, 8),               8, 32'h0000_00a0, 32'h20, class_r);  // sll
        add_row(enc_r(0, 1, 2, 5, 9),               9, 32'h07ff_ffff, 32'h24, class_r);  // srl
        add_row(enc_r(32, 1, 2, 5, 10),            10, 32'hffff_ffff, 32'h28, class_r);  // sra
        add_row(enc_r(0, 1, 2, 2, 11),             11, 32'h0000_0001, 32'h2c, class_r);  // slt
        add_row(enc_r(0, 1, 2, 3, 12),             12, 32'h0000_0000, 32'h30, class_r);  // sltu
        add_row(enc_i(32'h0f0, 2, 7, 13, op_imm),  13, 32'h0000_00f0, 32'h34, class_i);
        add_row(enc_i(-16, 1, 6, 14, op_imm),      14, 32'hffff_fff5, 32'h38, class_i);
        add_row(enc_i(-1, 1, 4, 15, op_imm),       15, 32'hffff_fffa, 32'h3c, class_i);
        add_row(enc_i(-1, 1, 3, 16, op_imm),       16, 32'h0000_0001, 32'h40, class_i);
        add_row(enc_i(28, 1, 1, 17, op_imm),       17, 32'h5000_0000, 32'h44, class_i);
        add_row(enc_i(28, 2, 5, 18, op_imm),       18, 32'h0000_000f, 32'h48, class_i);
        add_row(enc_i(32'h401, 2, 5, 19, op_imm),  19, 32'hffff_fffe, 32'h4c, class_i);  // srai
        add_row(enc_i(7, 1, 0, 0, op_imm),          0, 32'h0000_000c, 32'h50, class_i);
        add_row(enc_r(0, 1, 0, 0, 20),             20, 32'h0000_0005, 32'h54, class_r);  // x0 is 0
        add_branch(enc_b(8, 2, 1, 0), 32'h58);  // beq
        add_branch(enc_b(8, 1, 1, 0), 32'h60);
        add_skip();
        add_branch(enc_b(8, 1, 1, 1), 32'h64);  // bne
        add_branch(enc_b(8, 2, 1, 1), 32'h6c);
        add_skip();
        add_branch(enc_b(8, 2, 1, 4), 32'h70);  // blt
        add_branch(enc_b(8, 1, 2, 4), 32'h78);
        add_skip();
        add_branch(enc_b(8, 1, 2, 5), 32'h7c);  // bge
        add_branch(enc_b(8, 2, 1, 5), 32'h84);
        add_skip();
        add_branch(enc_b(8, 1, 2, 6), 32'h88);  // bltu
        add_branch(enc_b(8, 2, 1, 6), 32'h90);
        add_skip();
        add_branch(enc_b(8, 2, 1, 7), 32'h94);  // bgeu
        add_branch(enc_b(8, 1, 2, 7), 32'h9c);
        add_skip();
        add_row(enc_j(8, 21),                      21, 32'h0000_00a0, 32'ha4, class_j);
        add_skip();
        add_row(enc_u(32'h12345, 22, op_lui),      22, 32'h1234_5000, 32'ha8, class_u);
        add_row(enc_u(1, 23, op_auipc),            23, 32'h0000_10a8, 32'hac, class_u);
        add_row(enc_i(32'hc1, 0, 0, 24, op_imm),   24, 32'h0000_00c1, 32'hb0, class_i);
        add_row(enc_i(0, 24, 0, 25, op_jalr),      25, 32'h0000_00b4, 32'hc0, class_i);  // Bit 0 cleared.
        add_skip();
        add_skip();
        add_skip();
        add_row(enc_r(0, 25, 21, 0, 26),           26, 32'h0000_0154, 32'hc4, class_r);
        add_row(32'h0010_0073,                      0, 32'h0000_0000, 32'hc8, class_n);  // ebreak
    endtask

    task automatic build_illegal();
        n_rows   = 0;
        err_addr = 32'hffff_ffff;
        add_row(enc_i(1, 0, 0, 1, op_imm), 1, 32'h1, 32'h4, class_i);
        add_row(enc_i(0, 1, 2, 2, 7'h03),  0, 32'h0, 32'h8, class_bad);  // lw x2, 0(x1)
    endtask

    task automatic build_bus_error();
        n_rows   = 0;
        err_addr = 32'h4;
        add_row(enc_i(1, 0, 0, 1, op_imm), 1, 32'h1, 32'h4, class_i);
    endtask

    task automatic reset_and_load();
        @(posedge clk);
        #1;
        rst = 1'b1;
        for (int k = 0; k < 256; k++) begin
            mem[k] = {16'hdead, k[7:0], 8'h00};
        end
        for (int k = 0; k < n_rows; k++) begin
            mem[k] = t_inst[k];
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic wait_retire_or_halt(input string name, output bit got, output int lat);
        int start;
        start = -1;
        got   = 1'b0;
        lat   = 0;
        for (int n = 0; n < 64; n++) begin
            @(negedge clk);
            if (psel && start < 0) begin
                start = n;
            end
            if (retire_valid) begin
                got = 1'b1;
                lat = n - start;
                return;
            end
            if (halted) begin
                return;
            end
        end
        report_failure($sformatf("%s: timed out waiting for a retire or a halt", name));
    endtask

    task automatic run_program(input string name, input halt_cause_e cause,
                               input logic [31:0] end_pc);
        rv_retire_t  exp_ret;
        rv_perf_t    exp_perf;
        logic [31:0] exp_pc;
        int          row;
        int          lat;
        bit          got;
        reset_and_load();
        exp_pc          = reset_pc;
        exp_perf        = '0;
        exp_perf.cycles = 32'd1;  // Boot cycle after reset.
        got             = 1'b1;
        while (got) begin
            wait_retire_or_halt(name, got, lat);
            if (got) begin
                row = int'(exp_pc >> 2);
                if (row >= n_rows) begin
                    report_failure($sformatf("%s: retire at pc %h past the program",
                                             name, retire.pc));
                end
                exp_ret.pc         = exp_pc;
                exp_ret.next_pc    = t_next[row];
                exp_ret.wdata      = t_wdata[row];
                exp_ret.rd         = t_rd[row];
                exp_ret.gpr_we     = writes_gpr(t_class[row]);
                exp_ret.inst_class = t_class[row];
                check_retire($sformatf("%s row %0d", name, row), exp_ret, retire);
                check_count($sformatf("%s row %0d latency", name, row), 4 + last_waits, lat);
                // Fetch start to the next fetch start is six cycles plus wait states.
                exp_perf.cycles  = exp_perf.cycles + 32'(6 + last_waits);
                exp_perf.retired = exp_perf.retired + 32'd1;
                case (t_class[row])
                    class_r: exp_perf.r_cnt = exp_perf.r_cnt + 16'd1;
                    class_i: exp_perf.i_cnt = exp_perf.i_cnt + 16'd1;
                    class_b: exp_perf.b_cnt = exp_perf.b_cnt + 16'd1;
                    class_u: exp_perf.u_cnt = exp_perf.u_cnt + 16'd1;
                    class_j: exp_perf.j_cnt = exp_perf.j_cnt + 16'd1;
                    default: ;
                endcase
                exp_pc = t_next[row];
            end
        end
        if (cause == halt_bus_error) begin
            exp_perf.cycles = exp_perf.cycles + 32'(4 + last_waits);  // Failed fetch to halt.
        end
        check_count($sformatf("%s end pc", name), int'(end_pc), int'(exp_pc));
        check_cause($sformatf("%s halt cause", name), cause, halt_cause);
        check_perf($sformatf("%s counters", name), exp_perf, perf);
        repeat (16) begin
            @(negedge clk);
            if (psel) begin
                report_failure($sformatf("%s: a fetch started after the halt", name));
            end
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        prdata   = '0;
        pready   = 1'b0;
        pslverr  = 1'b0;
        seed     = 32'ha98;
        err_addr = 32'hffff_ffff;
        n_rows   = 0;
        build_main();
        run_program("main", halt_ebreak, 32'hc8);
        build_illegal();
        run_program("illegal", halt_illegal, 32'h8);
        build_bus_error();
        run_program("bus_error", halt_bus_error, 32'h4);  // Fetch at 4 never retires.
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- vlog.f
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_sequencer.sv
hw/rv_perf_counter.sv
hw/rv_core.sv
tb/tb_rv_core.sv

//--- Makefile
.PHONY: run clean

obj_dir/Vtb_rv_core: vlog.f $(wildcard hw/*.sv tb/*.sv)
	verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f vlog.f

run: obj_dir/Vtb_rv_core
	@out="$$(./obj_dir/Vtb_rv_core)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
